//--- include/fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// width of a data word and of one float register
`define FPU_WORD_W 32

// cycles from a CVTS being presented to its result
`define FPU_CVTS_CYCLES 2

// condition flags held in the FCSR
`define FPU_FCC_N 8

`endif

//--- verilog/fpu_pkg.sv
`default_nettype none

`include "fpu_settings.svh"

package fpu_pkg;

	typedef logic [`FPU_WORD_W-1:0] word_t;

	typedef enum logic [3:0] {
		FPU_OP_NOP,
		FPU_OP_MTC,   // gpr -> fpr
		FPU_OP_MFC,   // fpr -> gpr
		FPU_OP_ADD,
		FPU_OP_SUB,
		FPU_OP_MUL,
		FPU_OP_DIV,
		FPU_OP_SQRT,
		FPU_OP_COND,  // c.cond.s
		FPU_OP_CEIL,
		FPU_OP_FLOOR,
		FPU_OP_TRUNC,
		FPU_OP_ROUND,
		FPU_OP_CVTS,  // int32 -> single
		FPU_OP_CVTW   // single -> int32, mode from fcsr.rm
	} fpu_op_t;

	typedef struct packed {
		word_t val;
	} fpu_reg_t;

	typedef struct packed {
		logic [`FPU_FCC_N-1:0] fcc;
		logic [4:0]            flags;
		logic [4:0]            enables;
		logic [5:0]            cause;
		logic [5:0]            pad;
		logic [1:0]            rm;  // 0 nearest, 1 zero, 2 +inf, 3 -inf
	} fcsr_t;

	typedef struct packed {
		logic invalid;
		logic div_zero;
		logic overflow;
		logic underflow;
		logic inexact;
	} fpu_except_t;

	typedef struct packed {
		word_t ceil_val;
		word_t floor_val;
		word_t trunc_val;
		word_t round_val;
		logic  invalid_ceil;
		logic  invalid_floor;
		logic  invalid_trunc;
		logic  invalid_round;
	} f2i_result_t;

endpackage

`default_nettype wire

//--- verilog/fpu_compare.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_compare (
	input  fpu_pkg::word_t a,
	input  fpu_pkg::word_t b,
	input  logic [2:0]     cond,
	output logic           result
);

	logic       a_nan;
	logic       b_nan;
	logic       unordered;
	logic       both_zero;
	logic       equal;
	logic       less;
	logic       greater;
	logic [3:0] code;   // unordered, greater, less, equal
	logic [3:0] mask;

	assign a_nan     = (&a[30:23]) && (|a[22:0]);
	assign b_nan     = (&b[30:23]) && (|b[22:0]);
	assign unordered = a_nan | b_nan;
	assign both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);  // +0 == -0

	assign equal = !unordered && ((a == b) || both_zero);

	always_comb
	begin
		less = 1'b0;
		if (!unordered && !both_zero)
		begin
			if (a[31] != b[31])
			begin
				less = a[31];  // negative side is smaller
			end
			else if (a[31])
			begin
				less = a[30:0] > b[30:0];  // both negative, bigger magnitude is smaller
			end
			else
			begin
				less = a[30:0] < b[30:0];
			end
		end
	end

	assign greater = !unordered && !equal && !less;
	assign code    = {unordered, greater, less, equal};

	// mips predicate bits: 0 unordered, 1 equal, 2 less
	assign mask = {cond[0], 1'b0, cond[2], cond[1]};

	assign result = |(code & mask);

endmodule

`default_nettype wire

//--- verilog/fpu_float2int.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_float2int (
	input  fpu_pkg::word_t      float_in,
	output fpu_pkg::f2i_result_t result
);

	logic        sign;
	logic [7:0]  expo;
	logic [23:0] mant;
	logic        special;     // nan, inf or far out of range
	logic [7:0]  rsh;
	logic [55:0] ext;
	logic [32:0] int_part;    // magnitude before rounding
	logic        guard;
	logic        sticky;
	logic        inexact;
	logic [32:0] mag_ceil;
	logic [32:0] mag_floor;
	logic [32:0] mag_round;

	// returns {invalid, value} after range check and sign
	function automatic logic [32:0] apply_sign(
		input logic        neg,
		input logic [32:0] mag,
		input logic        bad
	);
		logic [32:0] limit;
		limit = neg ? 33'h080000000 : 33'h07fffffff;
		if (bad || (mag > limit))
		begin
			return {1'b1, 32'h7fffffff};
		end
		return {1'b0, neg ? -mag[31:0] : mag[31:0]};
	endfunction

	assign sign    = float_in[31];
	assign expo    = float_in[30:23];
	assign mant    = {expo != 8'd0, float_in[22:0]};  // hidden bit
	assign special = (expo == 8'hff) || (expo > 8'd158);

	always_comb
	begin
		rsh      = 8'd0;
		ext      = '0;
		int_part = '0;
		guard    = 1'b0;
		sticky   = 1'b0;
		if (expo >= 8'd150)
		begin
			int_part = {9'd0, mant} << (expo - 8'd150);  // exact, no fraction left
		end
		else
		begin
			rsh = 8'd150 - expo;
			if (rsh > 8'd26)
			begin
				rsh = 8'd26;  // past this only sticky matters
			end
			ext      = {mant, 32'd0} >> rsh;
			int_part = {9'd0, ext[55:32]};
			guard    = ext[31];
			sticky   = |ext[30:0];
		end
	end

	assign inexact = guard | sticky;

	// magnitude rounding, direction depends on sign for ceil/floor
	assign mag_ceil  = int_part + {32'd0, ~sign & inexact};
	assign mag_floor = int_part + {32'd0, sign & inexact};
	assign mag_round = int_part + {32'd0, guard & (sticky | int_part[0])};  // ties to even

	assign {result.invalid_ceil, result.ceil_val}   = apply_sign(sign, mag_ceil, special);
	assign {result.invalid_floor, result.floor_val} = apply_sign(sign, mag_floor, special);
	assign {result.invalid_trunc, result.trunc_val} = apply_sign(sign, int_part, special);
	assign {result.invalid_round, result.round_val} = apply_sign(sign, mag_round, special);

endmodule

`default_nettype wire

//--- verilog/fpu_int2float.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_int2float (
	input  logic           clk,
	input  logic           arst_n,
	input  fpu_pkg::word_t int_in,
	output fpu_pkg::word_t float_out
);

	// first half, normalize
	logic        sign_d;
	logic [31:0] mag;
	logic [5:0]  lz;
	logic [31:0] norm_d;
	logic [7:0]  exp_d;

	// pipeline register
	logic        sign_q;
	logic        zero_q;
	logic [7:0]  exp_q;
	logic [31:0] norm_q;

	// second half, round and pack
	logic [23:0] mant;
	logic        guard;
	logic        sticky;
	logic [24:0] sum;
	logic [7:0]  exp_adj;
	logic [22:0] frac;

	assign sign_d = int_in[31];
	assign mag    = sign_d ? -int_in : int_in;  // 0x80000000 stays as is

	always_comb
	begin
		lz = 6'd32;
		for (int i = 0; i < 32; i++)
		begin
			if (mag[i])
			begin
				lz = 6'(31 - i);  // highest set bit wins
			end
		end
	end

	assign norm_d = mag << lz;
	assign exp_d  = 8'd158 - {2'b00, lz};  // 127 + 31 - lz

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sign_q <= 1'b0;
			zero_q <= 1'b1;
			exp_q  <= 8'd0;
		end
		else
		begin
			sign_q <= sign_d;
			zero_q <= (mag == 32'd0);
			exp_q  <= exp_d;
		end
	end

	always_ff @(posedge clk)
	begin
		norm_q <= norm_d;
	end

	assign mant   = norm_q[31:8];
	assign guard  = norm_q[7];
	assign sticky = |norm_q[6:0];
	assign sum    = {1'b0, mant} + {24'd0, guard & (sticky | mant[0])};

	// carry out of the mantissa bumps the exponent
	assign exp_adj = exp_q + {7'd0, sum[24]};
	assign frac    = sum[24] ? sum[23:1] : sum[22:0];

	assign float_out = zero_q ? 32'd0 : {sign_q, exp_adj, frac};

endmodule

`default_nettype wire

//--- verilog/fpu_cycle_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fpu_cycle_ctrl (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             flush,
	input  fpu_pkg::fpu_op_t op,
	output logic             busy
);
	import fpu_pkg::*;

	localparam int STAGE_W = 32;

	logic [5:0]         cyc_number;
	logic [STAGE_W-1:0] stage;  // one-hot countdown

	always_comb
	begin
		if (flush)
		begin
			cyc_number = 6'd1;  // drops busy right away
		end
		else
		begin
			unique case (op)
				FPU_OP_ADD, FPU_OP_SUB, FPU_OP_MUL: cyc_number = 6'd2;
				FPU_OP_DIV:  cyc_number = 6'd29;
				FPU_OP_SQRT: cyc_number = 6'd5;
				FPU_OP_CVTS: cyc_number = 6'(`FPU_CVTS_CYCLES);
				default:     cyc_number = 6'd1;
			endcase
		end
	end

	assign busy = (cyc_number != 6'd1) && !stage[0];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			stage <= '0;
		end
		else if (flush)
		begin
			stage <= '0;
		end
		else if (stage != '0)
		begin
			stage <= stage >> 1;
		end
		else
		begin
			stage <= (STAGE_W'(1) << cyc_number) >> 2;  // bit 0 set after count-1 edges
		end
	end

endmodule

`default_nettype wire

//--- verilog/fpu_ex.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ex (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 flush,
	input  fpu_pkg::fpu_op_t     op,
	input  fpu_pkg::word_t       inst,
	input  fpu_pkg::fcsr_t       fcsr,
	input  fpu_pkg::word_t       gpr2,
	input  fpu_pkg::fpu_reg_t    reg1,
	input  fpu_pkg::fpu_reg_t    reg2,
	output logic                 fcsr_we,
	output fpu_pkg::fcsr_t       fcsr_wdata,
	output fpu_pkg::fpu_reg_t    fpu_ret,
	output fpu_pkg::word_t       cpu_ret,
	output fpu_pkg::fpu_except_t except,
	output logic                 busy
);
	import fpu_pkg::*;

	logic        ret_compare;
	f2i_result_t f2i;
	word_t       ret_i2f;
	word_t       ret;
	logic        invalid_sel;  // invalid bit of the chosen conversion

	fpu_cycle_ctrl u_cycle_ctrl (
		.clk    (clk),
		.arst_n (arst_n),
		.flush  (flush),
		.op     (op),
		.busy   (busy)
	);

	fpu_float2int u_float2int (
		.float_in (reg1.val),
		.result   (f2i)
	);

	fpu_int2float u_int2float (
		.clk       (clk),
		.arst_n    (arst_n),
		.int_in    (reg1.val),
		.float_out (ret_i2f)
	);

	fpu_compare u_compare (
		.a      (reg1.val),
		.b      (reg2.val),
		.cond   (inst[2:0]),
		.result (ret_compare)
	);

	always_comb
	begin
		ret         = '0;
		invalid_sel = 1'b0;
		unique case (op)
			FPU_OP_MTC:   ret = gpr2;
			FPU_OP_CEIL:  {invalid_sel, ret} = {f2i.invalid_ceil, f2i.ceil_val};
			FPU_OP_FLOOR: {invalid_sel, ret} = {f2i.invalid_floor, f2i.floor_val};
			FPU_OP_TRUNC: {invalid_sel, ret} = {f2i.invalid_trunc, f2i.trunc_val};
			FPU_OP_ROUND: {invalid_sel, ret} = {f2i.invalid_round, f2i.round_val};
			FPU_OP_CVTS:  ret = ret_i2f;
			FPU_OP_CVTW:
			begin
				unique case (fcsr.rm)
					2'd0: {invalid_sel, ret} = {f2i.invalid_round, f2i.round_val};
					2'd1: {invalid_sel, ret} = {f2i.invalid_trunc, f2i.trunc_val};
					2'd2: {invalid_sel, ret} = {f2i.invalid_ceil, f2i.ceil_val};
					2'd3: {invalid_sel, ret} = {f2i.invalid_floor, f2i.floor_val};
				endcase
			end
			default:      ret = '0;  // arithmetic not built, nop
		endcase
	end

	assign fpu_ret.val = ret;
	assign cpu_ret     = (op == FPU_OP_MFC) ? reg2.val : '0;

	always_comb
	begin
		except         = '0;
		except.invalid = invalid_sel;
	end

	// fcc index sits in inst[10:8] of c.cond.s
	assign fcsr_we = (op == FPU_OP_COND);

	always_comb
	begin
		fcsr_wdata                 = fcsr;
		fcsr_wdata.fcc[inst[10:8]] = ret_compare;
	end

endmodule

`default_nettype wire

//--- tb/fpu_ex_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_ex_tb;
	import fpu_pkg::*;

	localparam int TOTAL_OPS      = 1 + 200 * 8 + 300 * 8 + 200 + 12;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 4 + 100;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        flush;
	fpu_op_t     op;
	word_t       inst;
	fcsr_t       fcsr;
	word_t       gpr2;
	fpu_reg_t    reg1;
	fpu_reg_t    reg2;
	logic        fcsr_we;
	fcsr_t       fcsr_wdata;
	fpu_reg_t    fpu_ret;
	word_t       cpu_ret;
	fpu_except_t except;
	logic        busy;

	logic [31:0] lfsr = 32'h597c7838;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          test_err_base = 0;

	fpu_ex u_fpu_ex (
		.clk        (clk),
		.arst_n     (arst_n),
		.flush      (flush),
		.op         (op),
		.inst       (inst),
		.fcsr       (fcsr),
		.gpr2       (gpr2),
		.reg1       (reg1),
		.reg2       (reg2),
		.fcsr_we    (fcsr_we),
		.fcsr_wdata (fcsr_wdata),
		.fpu_ret    (fpu_ret),
		.cpu_ret    (cpu_ret),
		.except     (except),
		.busy       (busy)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("simulation stopped: no progress after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] next_rand(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic word_t rand_float();
		logic [3:0]  kind;
		logic [7:0]  e;
		logic [22:0] frac;
		logic        s;
		int          gpos;
		kind = 4'(next_rand(4));
		s    = next_rand(1) != 0;
		frac = 23'(next_rand(23));
		case (kind)
			4'd0: {e, frac} = {8'hff, frac | 23'd1};  // nan
			4'd1: {e, frac} = {8'hff, 23'd0};         // inf
			4'd2: {e, frac} = {8'h00, 23'd0};
			4'd3: e = 8'h00;                          // denormal
			4'd4, 4'd5:
			begin
				e    = 8'(127 + next_rand(5) % 23);
				gpos = 149 - int'(e);  // exact .5 tie
				frac = ((frac >> (gpos + 1)) << (gpos + 1)) | (23'd1 << gpos);
			end
			default: e = 8'(100 + next_rand(6) % 61);
		endcase
		return {s, e, frac};
	endfunction

	function automatic word_t rand_int();
		logic [31:0] t;
		logic [31:0] v;
		t = next_rand(23);
		case (next_rand(2))
			0: v = next_rand(32);
			1: v = next_rand(32) >> next_rand(5);
			2: v = {2'b01, t[22:0], 7'b1000000};  // tie at the rounding point
			default:
			begin
				case (next_rand(2))
					0: v = 32'h00000000;
					1: v = 32'h80000000;
					2: v = 32'h7fffffff;
					default: v = 32'hffffffff;
				endcase
			end
		endcase
		if (next_rand(1) != 0)
		begin
			v = -v;
		end
		return v;
	endfunction

	// ordering by a signed key, cond bit 0 unordered, 1 equal, 2 less
	function automatic logic cmp_model(input word_t a, input word_t b, input logic [2:0] c);
		logic   un;
		longint ka;
		longint kb;
		un = (a[30:23] == 8'hff && a[22:0] != 0) || (b[30:23] == 8'hff && b[22:0] != 0);
		ka = {33'd0, a[30:0]};
		kb = {33'd0, b[30:0]};
		if (a[31])
			ka = -ka;
		if (b[31])
			kb = -kb;
		return (c[0] & un) | (c[1] & !un & (ka == kb)) | (c[2] & !un & (ka < kb));
	endfunction

	// mode 0 ceil, 1 floor, 2 trunc, 3 round; returns {invalid, value}
	function automatic logic [32:0] f2i_model(input word_t f, input int mode);
		longint mant;
		longint q;
		longint r;
		longint half;
		longint val;
		int     e;
		int     sh;
		logic   up;
		e = int'(f[30:23]);
		if (e == 255 || e > 180)
			return {1'b1, 32'h7fffffff};
		mant = {40'd0, e != 0, f[22:0]};
		r    = 0;
		half = 1;
		if (e >= 150)
			q = mant << (e - 150);
		else
		begin
			sh   = (150 - e > 40) ? 40 : 150 - e;
			q    = mant >> sh;
			r    = mant - (q << sh);
			half = 64'sd1 << (sh - 1);
		end
		case (mode)
			0: up = (r != 0) && !f[31];
			1: up = (r != 0) && f[31];
			2: up = 1'b0;
			default: up = (r > half) || (r == half && q[0]);
		endcase
		val = f[31] ? -(q + longint'(up)) : q + longint'(up);
		if (val > 64'sh7fffffff || val < -64'sh80000000)
			return {1'b1, 32'h7fffffff};
		return {1'b0, val[31:0]};
	endfunction

	function automatic word_t i2f_model(input word_t v);
		longint m;
		longint q;
		longint r;
		longint half;
		int     p;
		int     sh;
		m = {32'd0, v};
		if (v[31])
			m = 64'sh100000000 - m;  // magnitude, 2^31 for the most negative
		if (m == 0)
			return 32'd0;
		p = 0;
		for (int i = 0; i < 32; i++)
			if (m[i])
				p = i;
		if (p <= 23)
			q = m << (23 - p);
		else
		begin
			sh   = p - 23;
			q    = m >> sh;
			r    = m - (q << sh);
			half = 64'sd1 << (sh - 1);
			if (r > half || (r == half && q[0]))
				q = q + 1;
			if (q == 64'sh1000000)
			begin
				q = q >> 1;
				p = p + 1;
			end
		end
		return {v[31], 8'(127 + p), q[22:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic drive_op(input fpu_op_t o, input word_t a, input word_t b,
		input word_t ins, input fcsr_t f, input word_t g, input logic fl);
		@(posedge clk);
		op       <= o;
		reg1.val <= a;
		reg2.val <= b;
		inst     <= ins;
		fcsr     <= f;
		gpr2     <= g;
		flush    <= fl;
		@(negedge clk);  // outputs settled
	endtask

	task automatic hold_cycle();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - test_err_base);
		test_err_base = errors;
	endtask

	initial
	begin
		word_t       a;
		word_t       b;
		word_t       ins;
		word_t       v;
		fcsr_t       f;
		fcsr_t       exp_f;
		logic [32:0] exp_r;
		int          mode;
		int          edges;
		arst_n   = 1'b0;
		flush    = 1'b0;
		op       = FPU_OP_NOP;
		inst     = '0;
		fcsr     = '0;
		gpr2     = '0;
		reg1     = '0;
		reg2     = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		drive_op(FPU_OP_NOP, 0, 0, 0, 0, 0, 0);
		check_value("busy", busy, 0);
		check_value("fcsr_we", fcsr_we, 0);
		check_value("fpu_ret", fpu_ret.val, 0);
		end_test(1, "reset");

		for (int n = 0; n < 200; n++)
		begin
			a = rand_float();
			case (next_rand(3))
				0: b = a;
				1: b = {~a[31], a[30:0]};
				2: {a, b} = {next_rand(1) != 0, 31'd0, next_rand(1) != 0, 31'd0};
				default: b = rand_float();
			endcase
			for (int c = 0; c < 8; c++)
			begin
				ins      = next_rand(32);
				ins[2:0] = 3'(c);
				f        = next_rand(32);
				drive_op(FPU_OP_COND, a, b, ins, f, 0, 0);
				exp_f                = f;
				exp_f.fcc[ins[10:8]] = cmp_model(a, b, 3'(c));
				check_value("fcsr_we", fcsr_we, 1);
				check_value("fcsr_wdata", fcsr_wdata, exp_f);
			end
		end
		end_test(2, "compare");

		for (int n = 0; n < 300; n++)
		begin
			a = rand_float();
			for (int m = 0; m < 8; m++)
			begin
				f = next_rand(32);
				if (m < 4)
				begin
					mode = m;
					drive_op(fpu_op_t'(int'(FPU_OP_CEIL) + m), a, 0, 0, f, 0, 0);
				end
				else
				begin
					f.rm = 2'(m - 4);
					case (f.rm)
						2'd0: mode = 3;  // nearest
						2'd1: mode = 2;  // toward zero
						2'd2: mode = 0;  // toward +inf
						default: mode = 1;
					endcase
					drive_op(FPU_OP_CVTW, a, 0, 0, f, 0, 0);
				end
				exp_r = f2i_model(a, mode);
				check_value("fpu_ret", fpu_ret.val, exp_r[31:0]);
				check_value("except", 32'(except), {27'd0, exp_r[32], 4'd0});
			end
		end
		end_test(3, "float to int");

		for (int n = 0; n < 200; n++)
		begin
			v = rand_int();
			drive_op(FPU_OP_CVTS, v, 0, 0, 0, 0, 0);
			check_value("busy", busy, 1);
			edges = 0;
			while (busy && edges < 8)
			begin
				hold_cycle();
				edges++;
			end
			if (busy)
			begin
				errors++;
				$display("busy never went low after a CVTS of %h", v);
			end
			check_value("cvts_edges", edges, 1);
			check_value("fpu_ret", fpu_ret.val, i2f_model(v));
		end
		drive_op(FPU_OP_NOP, 0, 0, 0, 0, 0, 0);
		end_test(4, "int to float");

		for (int n = 0; n < 4; n++)
		begin
			v = next_rand(32);
			drive_op(FPU_OP_MTC, next_rand(32), next_rand(32), 0, 0, v, 0);
			check_value("fpu_ret", fpu_ret.val, v);
			check_value("cpu_ret", cpu_ret, 0);
			v = next_rand(32);
			drive_op(FPU_OP_MFC, next_rand(32), v, 0, 0, next_rand(32), 0);
			check_value("cpu_ret", cpu_ret, v);
			check_value("fpu_ret", fpu_ret.val, 0);
		end
		v = rand_int();
		drive_op(FPU_OP_CVTS, v, 0, 0, 0, 0, 0);
		check_value("busy", busy, 1);
		hold_cycle();
		check_value("busy", busy, 0);
		drive_op(FPU_OP_CVTS, v, 0, 0, 0, 0, 1);  // a new pass would raise busy here
		check_value("busy", busy, 0);
		drive_op(FPU_OP_NOP, 0, 0, 0, 0, 0, 0);
		check_value("busy", busy, 0);
		end_test(5, "moves and flush");

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
verilog/fpu_pkg.sv
verilog/fpu_compare.sv
verilog/fpu_float2int.sv
verilog/fpu_int2float.sv
verilog/fpu_cycle_ctrl.sv
verilog/fpu_ex.sv
tb/fpu_ex_tb.sv

//--- Bender.yml
package:
  name: fpu_ex

sources:
  - include_dirs:
      - include
    files:
      - verilog/fpu_pkg.sv
      - verilog/fpu_compare.sv
      - verilog/fpu_float2int.sv
      - verilog/fpu_int2float.sv
      - verilog/fpu_cycle_ctrl.sv
      - verilog/fpu_ex.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/fpu_ex_tb.sv
